//--- source/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

   typedef enum logic [2:0] {
      OP_NONE,
      OP_MFC0,
      OP_MTC0,
      OP_ERET,
      OP_SYSCALL,
      OP_BREAK,
      OP_RESERVED
   } cp0_op_t;

   // register numbers in the rd field
   localparam logic [4:0] CP0_BADVADDR = 5'd8;
   localparam logic [4:0] CP0_COUNT    = 5'd9;
   localparam logic [4:0] CP0_COMPARE  = 5'd11;
   localparam logic [4:0] CP0_STATUS   = 5'd12;
   localparam logic [4:0] CP0_CAUSE    = 5'd13;
   localparam logic [4:0] CP0_EPC      = 5'd14;
   localparam logic [4:0] CP0_PRID     = 5'd15; // ebase at sel 1
   localparam logic [4:0] CP0_CONFIG   = 5'd16; // config1 at sel 1

   localparam logic [4:0] EXC_INT  = 5'd0;
   localparam logic [4:0] EXC_ADEL = 5'd4;
   localparam logic [4:0] EXC_ADES = 5'd5;
   localparam logic [4:0] EXC_SYS  = 5'd8;
   localparam logic [4:0] EXC_BP   = 5'd9;
   localparam logic [4:0] EXC_RI   = 5'd10;
   localparam logic [4:0] EXC_ERET = 5'd31; // internal only, never lands in cause

   // status fields
   localparam int IE_BIT  = 0;
   localparam int EXL_BIT = 1;
   localparam int IM_HI   = 15;
   localparam int IM_LO   = 8;
   localparam int BEV_BIT = 22;

   // cause fields
   localparam int BD_BIT     = 31;
   localparam int TI_BIT     = 30;
   localparam int IP_HI      = 15;
   localparam int IP_LO      = 8;
   localparam int IP7_BIT    = 15; // timer line
   localparam int IPHW_HI    = 14;
   localparam int IPHW_LO    = 10;
   localparam int IPSW_HI    = 9;  // software interrupts
   localparam int IPSW_LO    = 8;
   localparam int EXCCODE_HI = 6;
   localparam int EXCCODE_LO = 2;

   localparam logic [31:0] BOOT_EXC_VECTOR = 32'hbfc00380;
   localparam logic [31:0] EXC_OFFSET      = 32'h00000180;

endpackage

`default_nettype wire

//--- source/cp0_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_decode (
   input  logic [31:0]      instr,
   output cp0_pkg::cp0_op_t op,
   output logic [4:0]       reg_addr,
   output logic [2:0]       reg_sel,
   output logic [4:0]       rt
);

   localparam logic [5:0] OPC_SPECIAL = 6'b000000;
   localparam logic [5:0] OPC_COP0    = 6'b010000;
   localparam logic [4:0] RS_MF       = 5'b00000;
   localparam logic [4:0] RS_MT       = 5'b00100;
   localparam logic [5:0] FN_SYSCALL  = 6'b001100;
   localparam logic [5:0] FN_BREAK    = 6'b001101;
   localparam logic [5:0] FN_ERET     = 6'b011000;

   logic [5:0] opcode;
   logic [4:0] rs;
   logic [5:0] funct;
   logic       move_zeros; // bits 10:3 must be clear for mfc0/mtc0
   logic       co_zeros;   // bits 24:6 must be clear for eret

   assign opcode   = instr[31:26];
   assign rs       = instr[25:21];
   assign funct    = instr[5:0];
   assign rt       = instr[20:16];
   assign reg_addr = instr[15:11];
   assign reg_sel  = instr[2:0];

   assign move_zeros = (instr[10:3] == 8'd0);
   assign co_zeros   = (instr[24:6] == 19'd0);

   always_comb begin
      op = cp0_pkg::OP_NONE;
      if (opcode == OPC_COP0) begin
         if (rs == RS_MF && move_zeros) begin
            op = cp0_pkg::OP_MFC0;
         end else if (rs == RS_MT && move_zeros) begin
            op = cp0_pkg::OP_MTC0;
         end else if (instr[25] && co_zeros && funct == FN_ERET) begin
            op = cp0_pkg::OP_ERET;
         end else begin
            op = cp0_pkg::OP_RESERVED; // any other cop0 form
         end
      end else if (opcode == OPC_SPECIAL) begin
         if (funct == FN_SYSCALL) begin
            op = cp0_pkg::OP_SYSCALL;
         end else if (funct == FN_BREAK) begin
            op = cp0_pkg::OP_BREAK;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/cp0_except.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_except (
   input  logic             clk,
   input  logic             rst,
   input  cp0_pkg::cp0_op_t op,
   input  logic             instr_valid,
   input  logic             stall,
   input  logic [31:0]      pc,
   input  logic             in_delay_slot,
   input  logic             mem_rd,
   input  logic             mem_wr,
   input  logic [31:0]      mem_addr,
   input  logic [31:0]      status,
   input  logic [31:0]      cause,
   input  logic [31:0]      epc,
   input  logic [31:0]      ebase,
   output logic             take_exc,
   output logic [4:0]       exc_code,
   output logic [31:0]      bad_addr,
   output logic             bad_addr_wen,
   output logic [31:0]      target,
   output logic             commit_write,
   output logic [31:0]      exc_epc,
   output logic             exc_bd
);

   logic accept;
   logic int_guard; // set the cycle after a flush
   logic int_pending;
   logic pc_err;
   logic load_err;
   logic store_err;
   logic exc_any;
   logic addr_err;

   assign accept = instr_valid & ~stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         int_guard <= 1'b0;
      end else begin
         int_guard <= take_exc;
      end
   end

   assign int_pending = status[cp0_pkg::IE_BIT] & ~status[cp0_pkg::EXL_BIT] & ~int_guard &
                        (|(cause[cp0_pkg::IP_HI:cp0_pkg::IP_LO] &
                           status[cp0_pkg::IM_HI:cp0_pkg::IM_LO]));

   assign pc_err    = |pc[1:0];
   assign load_err  = mem_rd & (|mem_addr[1:0]); // word accesses only
   assign store_err = mem_wr & (|mem_addr[1:0]);

   always_comb begin
      exc_any  = 1'b1;
      addr_err = 1'b0;
      exc_code = cp0_pkg::EXC_INT;
      bad_addr = pc;
      if (int_pending) begin
         exc_code = cp0_pkg::EXC_INT;
      end else if (pc_err) begin
         exc_code = cp0_pkg::EXC_ADEL;
         addr_err = 1'b1;
      end else if (op == cp0_pkg::OP_RESERVED) begin
         exc_code = cp0_pkg::EXC_RI;
      end else if (op == cp0_pkg::OP_SYSCALL) begin
         exc_code = cp0_pkg::EXC_SYS;
      end else if (op == cp0_pkg::OP_BREAK) begin
         exc_code = cp0_pkg::EXC_BP;
      end else if (load_err || store_err) begin
         exc_code = load_err ? cp0_pkg::EXC_ADEL : cp0_pkg::EXC_ADES;
         bad_addr = mem_addr;
         addr_err = 1'b1;
      end else if (op == cp0_pkg::OP_ERET) begin
         exc_code = cp0_pkg::EXC_ERET; // return goes through the same flush path
      end else begin
         exc_any = 1'b0;
      end
   end

   assign take_exc     = accept & exc_any;
   assign bad_addr_wen = accept & addr_err;
   assign commit_write = accept & ~exc_any & (op == cp0_pkg::OP_MTC0);

   assign exc_epc = in_delay_slot ? pc - 32'd4 : pc; // point back at the branch
   assign exc_bd  = in_delay_slot;

   always_comb begin
      if (exc_code == cp0_pkg::EXC_ERET) begin
         target = epc;
      end else if (status[cp0_pkg::BEV_BIT]) begin
         target = cp0_pkg::BOOT_EXC_VECTOR;
      end else begin
         target = ebase + cp0_pkg::EXC_OFFSET;
      end
   end

endmodule

`default_nettype wire

//--- source/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs #(
   parameter logic [31:0] PRID_VALUE  = 32'h004c0102,
   parameter logic [31:0] RESET_EBASE = 32'h80000000
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [5:0]  ext_int,
   input  logic        stall,
   input  logic [4:0]  reg_addr,
   input  logic [2:0]  reg_sel,
   input  logic [31:0] wdata,
   input  logic        commit_write,
   input  logic        take_exc,
   input  logic [4:0]  exc_code,
   input  logic [31:0] exc_epc,
   input  logic        exc_bd,
   input  logic [31:0] bad_addr,
   input  logic        bad_addr_wen,
   output logic [31:0] rdata,
   output logic [31:0] status,
   output logic [31:0] cause,
   output logic [31:0] epc,
   output logic [31:0] ebase
);

   localparam logic [31:0] STATUS_RESET  = 32'd1 << cp0_pkg::BEV_BIT;
   localparam logic [31:0] CONFIG_RESET  = 32'h00008000;
   localparam logic [31:0] CONFIG1_VALUE = 32'h00000000; // no tlb, caches or fpu

   logic [31:0] badvaddr_q;
   logic [31:0] count_q;
   logic [31:0] compare_q;
   logic [31:0] status_q;
   logic [31:0] cause_q;
   logic [31:0] epc_q;
   logic [31:0] ebase_q;
   logic [31:0] config_q;
   logic        count_tick; // count advances on every other edge

   logic sel0;
   logic sel1;
   logic wr_count;
   logic wr_compare;
   logic wr_status;
   logic wr_cause;
   logic wr_epc;
   logic wr_ebase;
   logic wr_config;
   logic is_eret;
   logic timer_hit;
   logic timer_next;

   assign sel0 = (reg_sel == 3'd0);
   assign sel1 = (reg_sel == 3'd1);

   assign wr_count   = commit_write & (reg_addr == cp0_pkg::CP0_COUNT);
   assign wr_compare = commit_write & (reg_addr == cp0_pkg::CP0_COMPARE);
   assign wr_status  = commit_write & (reg_addr == cp0_pkg::CP0_STATUS);
   assign wr_cause   = commit_write & (reg_addr == cp0_pkg::CP0_CAUSE);
   assign wr_epc     = commit_write & (reg_addr == cp0_pkg::CP0_EPC);
   assign wr_ebase   = commit_write & (reg_addr == cp0_pkg::CP0_PRID) & sel1;
   assign wr_config  = commit_write & (reg_addr == cp0_pkg::CP0_CONFIG) & sel0;

   assign is_eret = (exc_code == cp0_pkg::EXC_ERET);

   // timer line stays up until compare is rewritten
   assign timer_hit  = (compare_q != 32'd0) && (count_q == compare_q);
   assign timer_next = wr_compare ? 1'b0 : (timer_hit | cause_q[cp0_pkg::TI_BIT]);

   always_ff @(posedge clk) begin
      if (rst) begin
         count_tick <= 1'b0;
         count_q    <= 32'd0;
         compare_q  <= 32'd0;
         status_q   <= STATUS_RESET;
         cause_q    <= 32'd0;
         ebase_q    <= RESET_EBASE;
         config_q   <= CONFIG_RESET;
      end else begin
         count_tick <= ~count_tick;
         if (wr_count) begin
            count_q <= wdata;
         end else if (count_tick) begin
            count_q <= count_q + 32'd1;
         end

         if (wr_compare) begin
            compare_q <= wdata;
         end

         cause_q[cp0_pkg::TI_BIT]  <= timer_next;
         cause_q[cp0_pkg::IP7_BIT] <= timer_next | (~stall & ext_int[5]);
         cause_q[cp0_pkg::IPHW_HI:cp0_pkg::IPHW_LO] <= stall ? 5'd0 : ext_int[4:0];

         if (take_exc) begin
            if (is_eret) begin
               status_q[cp0_pkg::EXL_BIT] <= 1'b0;
            end else begin
               status_q[cp0_pkg::EXL_BIT] <= 1'b1;
               cause_q[cp0_pkg::BD_BIT]   <= exc_bd;
               cause_q[cp0_pkg::EXCCODE_HI:cp0_pkg::EXCCODE_LO] <= exc_code;
            end
         end

         if (wr_status) begin
            status_q[cp0_pkg::IE_BIT]  <= wdata[cp0_pkg::IE_BIT];
            status_q[cp0_pkg::EXL_BIT] <= wdata[cp0_pkg::EXL_BIT];
            status_q[cp0_pkg::BEV_BIT] <= wdata[cp0_pkg::BEV_BIT];
            status_q[cp0_pkg::IM_HI:cp0_pkg::IM_LO] <= wdata[cp0_pkg::IM_HI:cp0_pkg::IM_LO];
         end
         if (wr_cause) begin
            cause_q[cp0_pkg::IPSW_HI:cp0_pkg::IPSW_LO] <=
               wdata[cp0_pkg::IPSW_HI:cp0_pkg::IPSW_LO];
         end
         if (wr_ebase) begin
            ebase_q[29:12] <= wdata[29:12];
         end
         if (wr_config) begin
            config_q[30:25] <= wdata[30:25]; // k23 / ku
            config_q[2:0]   <= wdata[2:0];   // k0
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_exc && !is_eret) begin
         epc_q <= exc_epc;
      end else if (wr_epc) begin
         epc_q <= wdata;
      end
      if (bad_addr_wen) begin
         badvaddr_q <= bad_addr;
      end
   end

   always_comb begin
      case (reg_addr)
         cp0_pkg::CP0_BADVADDR: rdata = badvaddr_q;
         cp0_pkg::CP0_COUNT:    rdata = count_q;
         cp0_pkg::CP0_COMPARE:  rdata = compare_q;
         cp0_pkg::CP0_STATUS:   rdata = status_q;
         cp0_pkg::CP0_CAUSE:    rdata = cause_q;
         cp0_pkg::CP0_EPC:      rdata = epc_q;
         cp0_pkg::CP0_PRID:     rdata = sel0 ? PRID_VALUE : (sel1 ? ebase_q : 32'd0);
         cp0_pkg::CP0_CONFIG:   rdata = sel0 ? config_q : (sel1 ? CONFIG1_VALUE : 32'd0);
         default:               rdata = 32'd0;
      endcase
   end

   assign status = status_q;
   assign cause  = cause_q;
   assign epc    = epc_q;
   assign ebase  = ebase_q;

endmodule

`default_nettype wire

//--- source/cp0_result.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_result (
   input  logic             clk,
   input  logic             rst,
   input  cp0_pkg::cp0_op_t op,
   input  logic [4:0]       rt,
   input  logic [31:0]      rdata,
   input  logic             take_exc,
   input  logic [31:0]      target,
   input  logic             instr_valid,
   input  logic             stall,
   output logic             wb_valid,
   output logic [4:0]       wb_rt,
   output logic [31:0]      wb_data,
   output logic             flush,
   output logic [31:0]      flush_target
);

   logic wb_take;

   // an exception on the same instruction kills the writeback
   assign wb_take = instr_valid & ~stall & ~take_exc & (op == cp0_pkg::OP_MFC0);

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid <= 1'b0;
         flush    <= 1'b0;
      end else begin
         wb_valid <= wb_take;
         flush    <= take_exc; // take_exc is already low under stall
      end
   end

   // payload only moves on an accepted instruction
   always_ff @(posedge clk) begin
      if (wb_take) begin
         wb_rt   <= rt;
         wb_data <= rdata;
      end
      if (take_exc) begin
         flush_target <= target;
      end
   end

endmodule

`default_nettype wire

//--- source/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
   parameter logic [31:0] PRID_VALUE  = 32'h004c0102,
   parameter logic [31:0] RESET_EBASE = 32'h80000000
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] instr,
   input  logic        instr_valid,
   input  logic [31:0] pc,
   input  logic        in_delay_slot,
   input  logic        mem_rd,
   input  logic        mem_wr,
   input  logic [31:0] mem_addr,
   input  logic [5:0]  ext_int,
   input  logic        stall,
   output logic        wb_valid,
   output logic [4:0]  wb_rt,
   output logic [31:0] wb_data,
   output logic        flush,
   output logic [31:0] flush_target
);

   cp0_pkg::cp0_op_t op;
   logic [4:0]       reg_addr;
   logic [2:0]       reg_sel;
   logic [4:0]       rt;
   logic [31:0]      status;
   logic [31:0]      cause;
   logic [31:0]      epc;
   logic [31:0]      ebase;
   logic [31:0]      rdata;
   logic             take_exc;
   logic [4:0]       exc_code;
   logic [31:0]      bad_addr;
   logic             bad_addr_wen;
   logic [31:0]      target;
   logic             commit_write;
   logic [31:0]      exc_epc;
   logic             exc_bd;

   cp0_decode u_decode (
      .instr    (instr),
      .op       (op),
      .reg_addr (reg_addr),
      .reg_sel  (reg_sel),
      .rt       (rt)
   );

   cp0_except u_except (
      .clk           (clk),
      .rst           (rst),
      .op            (op),
      .instr_valid   (instr_valid),
      .stall         (stall),
      .pc            (pc),
      .in_delay_slot (in_delay_slot),
      .mem_rd        (mem_rd),
      .mem_wr        (mem_wr),
      .mem_addr      (mem_addr),
      .status        (status),
      .cause         (cause),
      .epc           (epc),
      .ebase         (ebase),
      .take_exc      (take_exc),
      .exc_code      (exc_code),
      .bad_addr      (bad_addr),
      .bad_addr_wen  (bad_addr_wen),
      .target        (target),
      .commit_write  (commit_write),
      .exc_epc       (exc_epc),
      .exc_bd        (exc_bd)
   );

   // mtc0 data arrives on the memory-stage result bus
   cp0_regs #(
      .PRID_VALUE  (PRID_VALUE),
      .RESET_EBASE (RESET_EBASE)
   ) u_regs (
      .clk          (clk),
      .rst          (rst),
      .ext_int      (ext_int),
      .stall        (stall),
      .reg_addr     (reg_addr),
      .reg_sel      (reg_sel),
      .wdata        (mem_addr),
      .commit_write (commit_write),
      .take_exc     (take_exc),
      .exc_code     (exc_code),
      .exc_epc      (exc_epc),
      .exc_bd       (exc_bd),
      .bad_addr     (bad_addr),
      .bad_addr_wen (bad_addr_wen),
      .rdata        (rdata),
      .status       (status),
      .cause        (cause),
      .epc          (epc),
      .ebase        (ebase)
   );

   cp0_result u_result (
      .clk          (clk),
      .rst          (rst),
      .op           (op),
      .rt           (rt),
      .rdata        (rdata),
      .take_exc     (take_exc),
      .target       (target),
      .instr_valid  (instr_valid),
      .stall        (stall),
      .wb_valid     (wb_valid),
      .wb_rt        (wb_rt),
      .wb_data      (wb_data),
      .flush        (flush),
      .flush_target (flush_target)
   );

endmodule

`default_nettype wire

//--- test/cp0_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;

   localparam logic [31:0] PRID          = 32'h004c0102;
   localparam logic [31:0] EBASE         = 32'h80000000;
   localparam logic [31:0] INSTR_NOP     = 32'h00000000;
   localparam logic [31:0] INSTR_SYSCALL = 32'h0000000c;
   localparam logic [31:0] INSTR_ERET    = 32'h42000018;
   localparam int          MAX_CYCLES    = 2000; // all tests need a few hundred cycles

   logic        clk = 1'b0;
   logic        rst;
   logic [31:0] instr;
   logic        instr_valid;
   logic [31:0] pc;
   logic        in_delay_slot;
   logic        mem_rd;
   logic        mem_wr;
   logic [31:0] mem_addr;
   logic [5:0]  ext_int;
   logic        stall;
   logic        wb_valid;
   logic [4:0]  wb_rt;
   logic [31:0] wb_data;
   logic        flush;
   logic [31:0] flush_target;

   logic [31:0] cur_pc;
   logic [31:0] ebase_exp;
   int          cycles = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          checks = 0;
   int          tests_run = 0;

   cp0_top #(
      .PRID_VALUE  (PRID),
      .RESET_EBASE (EBASE)
   ) u_dut (
      .clk           (clk),
      .rst           (rst),
      .instr         (instr),
      .instr_valid   (instr_valid),
      .pc            (pc),
      .in_delay_slot (in_delay_slot),
      .mem_rd        (mem_rd),
      .mem_wr        (mem_wr),
      .mem_addr      (mem_addr),
      .ext_int       (ext_int),
      .stall         (stall),
      .wb_valid      (wb_valid),
      .wb_rt         (wb_rt),
      .wb_data       (wb_data),
      .flush         (flush),
      .flush_target  (flush_target)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [31:0] mfc0_word(input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [2:0] sel);
      return {6'b010000, 5'b00000, rt, rd, 8'd0, sel};
   endfunction

   function automatic logic [31:0] mtc0_word(input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [2:0] sel);
      return {6'b010000, 5'b00100, rt, rd, 8'd0, sel};
   endfunction

   // cause as left by an exception, ip bits zero
   function automatic logic [31:0] cause_val(input logic bd, input logic [4:0] code);
      return (32'(bd) << cp0_pkg::BD_BIT) | (32'(code) << cp0_pkg::EXCCODE_LO);
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("%s: %0d mismatches", name, test_errors);
      tests_run++;
      test_errors = 0;
   endtask

   // called just after a rising edge, returns just after the next one
   task automatic issue_instr(input logic [31:0] word, input logic ds, input logic rd,
                              input logic wr, input logic [31:0] addr);
      instr         = word;
      instr_valid   = 1'b1;
      pc            = cur_pc;
      in_delay_slot = ds;
      mem_rd        = rd;
      mem_wr        = wr;
      mem_addr      = addr;
      @(posedge clk);
      #2;
      instr_valid   = 1'b0;
      in_delay_slot = 1'b0;
      mem_rd        = 1'b0;
      mem_wr        = 1'b0;
      cur_pc        = cur_pc + 32'd4;
   endtask

   task automatic read_cp0(input logic [4:0] rd, input logic [2:0] sel, input logic [4:0] rt,
                           output logic [31:0] data);
      issue_instr(mfc0_word(rt, rd, sel), 1'b0, 1'b0, 1'b0, 32'd0);
      check_eq("wb_valid", 32'(wb_valid), 32'd1);
      check_eq("wb_rt", 32'(wb_rt), 32'(rt));
      check_eq("flush", 32'(flush), 32'd0);
      data = wb_data;
   endtask

   task automatic expect_reg(input string name, input logic [4:0] rd, input logic [2:0] sel,
                             input logic [31:0] exp);
      logic [31:0] data;
      read_cp0(rd, sel, rd, data);
      check_eq(name, data, exp);
   endtask

   // mtc0 data rides on mem_addr
   task automatic write_cp0(input logic [4:0] rd, input logic [2:0] sel, input logic [31:0] data);
      issue_instr(mtc0_word(5'd8, rd, sel), 1'b0, 1'b0, 1'b0, data);
   endtask

   task automatic expect_flush(input logic [31:0] target);
      check_eq("flush", 32'(flush), 32'd1);
      check_eq("flush_target", flush_target, target);
      check_eq("wb_valid", 32'(wb_valid), 32'd0);
   endtask

   task automatic test_reset_values;
      expect_reg("prid", cp0_pkg::CP0_PRID, 3'd0, PRID);
      expect_reg("ebase", cp0_pkg::CP0_PRID, 3'd1, EBASE);
      expect_reg("config", cp0_pkg::CP0_CONFIG, 3'd0, 32'h00008000);
      expect_reg("status", cp0_pkg::CP0_STATUS, 3'd0, 32'h00400000);
      @(posedge clk);
      #2;
      check_eq("wb_valid", 32'(wb_valid), 32'd0); // single pulse
      finish_test("reset_values");
   endtask

   task automatic test_write_masking;
      logic [31:0] w;
      w = $urandom;
      write_cp0(cp0_pkg::CP0_CAUSE, 3'd0, w);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, w & 32'h00000300);
      write_cp0(cp0_pkg::CP0_CAUSE, 3'd0, 32'd0); // no sw interrupt while status is random
      w = $urandom;
      write_cp0(cp0_pkg::CP0_STATUS, 3'd0, w);
      expect_reg("status", cp0_pkg::CP0_STATUS, 3'd0, w & 32'h0040ff03);
      write_cp0(cp0_pkg::CP0_STATUS, 3'd0, 32'h00400000);
      w = $urandom;
      write_cp0(cp0_pkg::CP0_EPC, 3'd0, w);
      expect_reg("epc", cp0_pkg::CP0_EPC, 3'd0, w);
      w = $urandom;
      write_cp0(cp0_pkg::CP0_PRID, 3'd1, w);
      ebase_exp = (EBASE & ~32'h3ffff000) | (w & 32'h3ffff000);
      expect_reg("ebase", cp0_pkg::CP0_PRID, 3'd1, ebase_exp);
      w = $urandom;
      write_cp0(cp0_pkg::CP0_CONFIG, 3'd0, w);
      expect_reg("config", cp0_pkg::CP0_CONFIG, 3'd0,
                 (32'h00008000 & ~32'h7e000007) | (w & 32'h7e000007));
      write_cp0(cp0_pkg::CP0_PRID, 3'd0, $urandom);
      expect_reg("prid", cp0_pkg::CP0_PRID, 3'd0, PRID);
      expect_reg("unmapped", 5'd3, 3'd0, 32'd0);
      finish_test("write_masking");
   endtask

   task automatic test_syscall_eret;
      logic [31:0] epc_exp;
      epc_exp = cur_pc;
      issue_instr(INSTR_SYSCALL, 1'b0, 1'b0, 1'b0, 32'd0);
      expect_flush(cp0_pkg::BOOT_EXC_VECTOR);
      expect_reg("epc", cp0_pkg::CP0_EPC, 3'd0, epc_exp);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, cause_val(1'b0, cp0_pkg::EXC_SYS));
      write_cp0(cp0_pkg::CP0_STATUS, 3'd0, 32'd0); // bev and exl clear
      epc_exp = cur_pc - 32'd4; // branch before the slot
      issue_instr(INSTR_SYSCALL, 1'b1, 1'b0, 1'b0, 32'd0);
      expect_flush(ebase_exp + cp0_pkg::EXC_OFFSET);
      expect_reg("epc", cp0_pkg::CP0_EPC, 3'd0, epc_exp);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, cause_val(1'b1, cp0_pkg::EXC_SYS));
      issue_instr(INSTR_ERET, 1'b0, 1'b0, 1'b0, 32'd0);
      expect_flush(epc_exp);
      expect_reg("status", cp0_pkg::CP0_STATUS, 3'd0, 32'd0);
      finish_test("syscall_eret");
   endtask

   task automatic test_address_errors;
      logic [31:0] addr;
      addr = ($urandom & ~32'd3) | 32'd2;
      issue_instr(INSTR_NOP, 1'b0, 1'b1, 1'b0, addr);
      expect_flush(ebase_exp + cp0_pkg::EXC_OFFSET);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, cause_val(1'b0, cp0_pkg::EXC_ADEL));
      expect_reg("badvaddr", cp0_pkg::CP0_BADVADDR, 3'd0, addr);
      addr = ($urandom & ~32'd3) | 32'd1;
      issue_instr(INSTR_NOP, 1'b0, 1'b0, 1'b1, addr);
      expect_flush(ebase_exp + cp0_pkg::EXC_OFFSET);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, cause_val(1'b0, cp0_pkg::EXC_ADES));
      expect_reg("badvaddr", cp0_pkg::CP0_BADVADDR, 3'd0, addr);
      cur_pc = cur_pc + 32'd2;
      addr   = cur_pc;
      issue_instr(INSTR_NOP, 1'b0, 1'b0, 1'b0, 32'd0);
      cur_pc = cur_pc - 32'd2; // back on a word boundary
      expect_flush(ebase_exp + cp0_pkg::EXC_OFFSET);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, cause_val(1'b0, cp0_pkg::EXC_ADEL));
      expect_reg("badvaddr", cp0_pkg::CP0_BADVADDR, 3'd0, addr);
      write_cp0(cp0_pkg::CP0_STATUS, 3'd0, 32'd0);
      finish_test("address_errors");
   endtask

   task automatic test_interrupts;
      logic [31:0] cmp;
      logic [31:0] data;
      int          waited;
      int          limit;
      write_cp0(cp0_pkg::CP0_CAUSE, 3'd0, 32'h00000100);  // ip0
      write_cp0(cp0_pkg::CP0_STATUS, 3'd0, 32'h00000101); // im0 and ie
      issue_instr(INSTR_NOP, 1'b0, 1'b0, 1'b0, 32'd0);
      expect_flush(ebase_exp + cp0_pkg::EXC_OFFSET);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0,
                 32'h00000100 | cause_val(1'b0, cp0_pkg::EXC_INT));
      write_cp0(cp0_pkg::CP0_CAUSE, 3'd0, 32'd0);
      write_cp0(cp0_pkg::CP0_STATUS, 3'd0, 32'd0);

      cmp = 32'd16 + ($urandom & 32'hf);
      write_cp0(cp0_pkg::CP0_COUNT, 3'd0, 32'd0);
      write_cp0(cp0_pkg::CP0_COMPARE, 3'd0, cmp);
      limit  = 2 * int'(cmp) + 12;
      waited = 0;
      data   = 32'd0;
      while (data[cp0_pkg::IP7_BIT] == 1'b0 && waited < limit) begin
         read_cp0(cp0_pkg::CP0_CAUSE, 3'd0, 5'd2, data);
         waited++;
      end
      if (data[cp0_pkg::IP7_BIT] == 1'b0) begin
         $display("timer interrupt did not show up in Cause within %0d cycles", limit);
         errors++;
         test_errors++;
      end
      check_eq("cause", data, 32'h40008000); // ti and ip7
      write_cp0(cp0_pkg::CP0_COMPARE, 3'd0, 32'd0);
      expect_reg("cause", cp0_pkg::CP0_CAUSE, 3'd0, 32'd0);
      finish_test("interrupts");
   endtask

   task automatic test_stall;
      logic [31:0] w;
      w = $urandom;
      write_cp0(cp0_pkg::CP0_EPC, 3'd0, w);
      expect_reg("prid", cp0_pkg::CP0_PRID, 3'd0, PRID);
      stall       = 1'b1;
      instr       = mfc0_word(5'd9, cp0_pkg::CP0_EPC, 3'd0);
      instr_valid = 1'b1;
      pc          = cur_pc;
      repeat (3) begin
         @(posedge clk);
         #2;
         check_eq("wb_valid", 32'(wb_valid), 32'd0);
         check_eq("flush", 32'(flush), 32'd0);
         check_eq("wb_rt", 32'(wb_rt), 32'(cp0_pkg::CP0_PRID));
         check_eq("wb_data", wb_data, PRID);
         check_eq("flush_target", flush_target, ebase_exp + cp0_pkg::EXC_OFFSET);
      end
      stall = 1'b0;
      @(posedge clk);
      #2;
      instr_valid = 1'b0;
      cur_pc      = cur_pc + 32'd4;
      check_eq("wb_valid", 32'(wb_valid), 32'd1);
      check_eq("wb_rt", 32'(wb_rt), 32'd9);
      check_eq("wb_data", wb_data, w);
      finish_test("stall");
   endtask

   initial begin
      void'($urandom(32'h16a7));
      rst           = 1'b1;
      instr         = 32'd0;
      instr_valid   = 1'b0;
      pc            = 32'd0;
      in_delay_slot = 1'b0;
      mem_rd        = 1'b0;
      mem_wr        = 1'b0;
      mem_addr      = 32'd0;
      ext_int       = 6'd0;
      stall         = 1'b0;
      cur_pc        = 32'hbfc00000;
      ebase_exp     = EBASE;
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;

      test_reset_values();
      test_write_masking();
      test_syscall_eret();
      test_address_errors();
      test_interrupts();
      test_stall();

      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
source/cp0_pkg.sv
source/cp0_decode.sv
source/cp0_except.sv
source/cp0_regs.sv
source/cp0_result.sv
source/cp0_top.sv
test/cp0_tb.sv

//--- Makefile
# Verilator build for the CP0 testbench

VERILATOR ?= verilator
TOP       ?= cp0_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# pass or fail comes from the log, not the exit code
run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation reported failure, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
